// File: common/exec_pkg.sv
// Execute stage shared definitions
package exec_pkg;

	// Data path widths
	localparam int WORD_WIDTH = 32;
	localparam int REG_INDEX_WIDTH = 5;
	localparam int SHAMT_WIDTH = $clog2(WORD_WIDTH);

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

	// Register number that reads as the PC
	localparam reg_index_t PC_REG = 5'd31;

	// ALU operation codes
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SHL = 4'd5;
	localparam alu_op_t ALU_SHR = 4'd6;
	localparam alu_op_t ALU_EQ = 4'd7;
	localparam alu_op_t ALU_LTU = 4'd8;

	// Branch kinds
	typedef logic [2:0] branch_kind_t;

	localparam branch_kind_t BR_NONE = 3'd0;
	localparam branch_kind_t BR_ZERO = 3'd1;
	localparam branch_kind_t BR_NZERO = 3'd2;
	localparam branch_kind_t BR_GOTO = 3'd3;
	localparam branch_kind_t BR_CALL = 3'd4;

	// Signed offset field of branch instructions
	localparam int OFFSET_WIDTH = 20;

	// Data cache line geometry, 64 bytes split into 16 word lanes
	localparam int LINE_OFFSET_BITS = 6;
	localparam int LANE_WIDTH = 4;

	typedef logic [LANE_WIDTH-1:0] lane_t;

	// Decoded control from the previous stage
	typedef struct packed {
		alu_op_t alu_op;
		logic op2_is_imm;
		branch_kind_t branch_kind;
		logic is_mem;
		logic has_writeback;
		reg_index_t writeback_reg;
		logic [OFFSET_WIDTH-1:0] branch_offset;
	} exec_ctrl_t;

	// One result still in flight toward the register file
	typedef struct packed {
		logic has_writeback;
		reg_index_t writeback_reg;
		word_t value;
	} bypass_t;

endpackage

// File: design/branch_unit.sv
// Branch condition and target resolution
`timescale 1ns/1ns

module branch_unit (
	input  exec_pkg::exec_ctrl_t ctrl_i,
	input  exec_pkg::word_t pc_i,
	input  exec_pkg::word_t operand1_i,
	input  exec_pkg::word_t alu_result_i,
	output logic rollback_o,
	output exec_pkg::word_t rollback_address_o
);
	import exec_pkg::*;

	logic pc_write;
	logic branch_taken;
	word_t offset_ext;
	word_t branch_target;

	// Arithmetic write to r31 acts as an indirect jump
	// Loads cannot do this here, their data comes later
	assign pc_write = ctrl_i.has_writeback && (ctrl_i.writeback_reg == PC_REG)
		&& !ctrl_i.is_mem && (ctrl_i.branch_kind == BR_NONE);

	assign offset_ext = {{(WORD_WIDTH-OFFSET_WIDTH){ctrl_i.branch_offset[OFFSET_WIDTH-1]}},
		ctrl_i.branch_offset};
	assign branch_target = pc_i + offset_ext;

	always_comb
	begin
		case (ctrl_i.branch_kind)
			BR_ZERO: branch_taken = (operand1_i == '0);
			BR_NZERO: branch_taken = (operand1_i != '0);
			BR_GOTO: branch_taken = 1'b1;
			BR_CALL: branch_taken = 1'b1;
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (pc_write)
		begin
			rollback_o = 1'b1;
			rollback_address_o = alu_result_i;
		end
		else if (branch_taken)
		begin
			rollback_o = 1'b1;
			rollback_address_o = branch_target;
		end
		else
		begin
			rollback_o = 1'b0;
			rollback_address_o = '0;
		end
	end

endmodule

// File: design/execute_stage.sv
// Scalar execute stage
`timescale 1ns/1ns

module execute_stage (
	input  logic clk,
	input  logic reset_i,
	input  logic flush_i,
	input  exec_pkg::exec_ctrl_t ctrl_i,
	input  exec_pkg::word_t pc_i,
	input  exec_pkg::word_t immediate_i,
	input  exec_pkg::word_t value1_i,
	input  exec_pkg::reg_index_t sel1_i,
	input  exec_pkg::word_t value2_i,
	input  exec_pkg::reg_index_t sel2_i,
	input  exec_pkg::bypass_t mem_bypass_i,
	input  exec_pkg::bypass_t wb_bypass_i,
	output exec_pkg::word_t daddress_o,
	output exec_pkg::lane_t cache_lane_o,
	output logic daccess_o,
	output logic rollback_o,
	output exec_pkg::word_t rollback_address_o,
	output exec_pkg::word_t result_o,
	output logic has_writeback_o,
	output exec_pkg::reg_index_t writeback_reg_o,
	output exec_pkg::word_t pc_o,
	output logic was_access_o,
	output exec_pkg::lane_t reg_lane_o
);
	import exec_pkg::*;

	bypass_t own_bypass;
	word_t operand1;
	word_t operand2_reg;
	word_t operand2;
	word_t alu_result;
	word_t result_nxt;

	// Last cycle's result, not yet seen by the memory stage
	assign own_bypass.has_writeback = has_writeback_o;
	assign own_bypass.writeback_reg = writeback_reg_o;
	assign own_bypass.value = result_o;

	operand_bypass u_bypass1 (
		.sel_i(sel1_i),
		.regfile_value_i(value1_i),
		.pc_i(pc_i),
		.own_i(own_bypass),
		.mem_i(mem_bypass_i),
		.wb_i(wb_bypass_i),
		.value_o(operand1)
	);

	operand_bypass u_bypass2 (
		.sel_i(sel2_i),
		.regfile_value_i(value2_i),
		.pc_i(pc_i),
		.own_i(own_bypass),
		.mem_i(mem_bypass_i),
		.wb_i(wb_bypass_i),
		.value_o(operand2_reg)
	);

	assign operand2 = ctrl_i.op2_is_imm ? immediate_i : operand2_reg;

	scalar_alu u_alu (
		.op_i(ctrl_i.alu_op),
		.operand1_i(operand1),
		.operand2_i(operand2),
		.result_o(alu_result)
	);

	branch_unit u_branch (
		.ctrl_i(ctrl_i),
		.pc_i(pc_i),
		.operand1_i(operand1),
		.alu_result_i(alu_result),
		.rollback_o(rollback_o),
		.rollback_address_o(rollback_address_o)
	);

	// Tag lookup goes out in this cycle, so address and lane are not registered
	assign daddress_o = {alu_result[WORD_WIDTH-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
	assign cache_lane_o = alu_result[LINE_OFFSET_BITS-1 -: LANE_WIDTH];
	assign daccess_o = ctrl_i.is_mem && !flush_i;

	// Call saves its own PC as the link value
	assign result_nxt = (ctrl_i.branch_kind == BR_CALL) ? pc_i : alu_result;

	always_ff @(posedge clk)
	begin
		if (reset_i || flush_i)
		begin
			result_o <= '0;
			has_writeback_o <= 1'b0;
			writeback_reg_o <= '0;
			pc_o <= '0;
			was_access_o <= 1'b0;
			reg_lane_o <= '0;
		end
		else
		begin
			result_o <= result_nxt;
			has_writeback_o <= ctrl_i.has_writeback;
			writeback_reg_o <= ctrl_i.writeback_reg;
			pc_o <= pc_i;
			was_access_o <= daccess_o;
			reg_lane_o <= cache_lane_o;
		end
	end

	// Later stages may also claim r31, but the PC must still win
	assert property (@(posedge clk) (sel1_i == PC_REG) |-> (operand1 == pc_i))
	else $error("execute_stage: operand 1 from r31 did not read the PC");
	assert property (@(posedge clk) (sel2_i == PC_REG) |-> (operand2_reg == pc_i))
	else $error("execute_stage: operand 2 from r31 did not read the PC");

	// Compares feed branch tests as plain booleans
	assert property (@(posedge clk)
		((ctrl_i.alu_op == ALU_EQ) || (ctrl_i.alu_op == ALU_LTU)) |-> (alu_result <= word_t'(1)))
	else $error("execute_stage: compare result wider than one bit");

	// No target leaks out when nothing is taken
	assert property (@(posedge clk) !rollback_o |-> (rollback_address_o == '0))
	else $error("execute_stage: rollback address driven without rollback");

endmodule

// File: design/operand_bypass.sv
// Operand bypass select
`timescale 1ns/1ns

module operand_bypass (
	input  exec_pkg::reg_index_t sel_i,
	input  exec_pkg::word_t regfile_value_i,
	input  exec_pkg::word_t pc_i,
	input  exec_pkg::bypass_t own_i,
	input  exec_pkg::bypass_t mem_i,
	input  exec_pkg::bypass_t wb_i,
	output exec_pkg::word_t value_o
);
	import exec_pkg::*;

	logic own_hit;
	logic mem_hit;
	logic wb_hit;

	// A source only counts when it will really write this register
	function automatic logic source_hits(input bypass_t src, input reg_index_t sel);
		source_hits = src.has_writeback && (src.writeback_reg == sel);
	endfunction

	assign own_hit = source_hits(own_i, sel_i);
	assign mem_hit = source_hits(mem_i, sel_i);
	assign wb_hit = source_hits(wb_i, sel_i);

	// Youngest result wins, PC register overrides everything
	always_comb
	begin
		if (sel_i == PC_REG)
		begin
			value_o = pc_i;
		end
		else if (own_hit)
		begin
			value_o = own_i.value;
		end
		else if (mem_hit)
		begin
			value_o = mem_i.value;
		end
		else if (wb_hit)
		begin
			value_o = wb_i.value;
		end
		else
		begin
			value_o = regfile_value_i;
		end
	end

endmodule

// File: design/scalar_alu.sv
// Single cycle integer ALU
`timescale 1ns/1ns

module scalar_alu (
	input  exec_pkg::alu_op_t op_i,
	input  exec_pkg::word_t operand1_i,
	input  exec_pkg::word_t operand2_i,
	output exec_pkg::word_t result_o
);
	import exec_pkg::*;

	logic [SHAMT_WIDTH-1:0] shamt;

	// Only the low bits of operand 2 give the shift distance
	assign shamt = operand2_i[SHAMT_WIDTH-1:0];

	always_comb
	begin
		case (op_i)
			ALU_ADD:
			begin
				result_o = operand1_i + operand2_i;
			end
			ALU_SUB:
			begin
				result_o = operand1_i - operand2_i;
			end
			ALU_AND:
			begin
				result_o = operand1_i & operand2_i;
			end
			ALU_OR:
			begin
				result_o = operand1_i | operand2_i;
			end
			ALU_XOR:
			begin
				result_o = operand1_i ^ operand2_i;
			end
			ALU_SHL:
			begin
				result_o = operand1_i << shamt;
			end
			ALU_SHR:
			begin
				// Logical, zero fill from the top
				result_o = operand1_i >> shamt;
			end
			ALU_EQ:
			begin
				result_o = word_t'(operand1_i == operand2_i);
			end
			ALU_LTU:
			begin
				result_o = word_t'(operand1_i < operand2_i);
			end
			default:
			begin
				result_o = '0;
			end
		endcase
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_execute -Mdir obj_dir -f tb.f
./obj_dir/Vtb_execute

// File: tb.f
common/exec_pkg.sv
design/operand_bypass.sv
design/scalar_alu.sv
design/branch_unit.sv
design/execute_stage.sv
tb/exec_checker.sv
tb/tb_execute.sv

// File: tb/exec_checker.sv
// Execute stage reference checker
`timescale 1ns/1ns

module exec_checker (
	input  logic clk,
	input  logic reset_i,
	input  logic flush_i,
	input  exec_pkg::exec_ctrl_t ctrl_i,
	input  exec_pkg::word_t pc_i, immediate_i, value1_i, value2_i,
	input  exec_pkg::reg_index_t sel1_i, sel2_i,
	input  exec_pkg::bypass_t mem_bypass_i, wb_bypass_i,
	input  exec_pkg::word_t daddress_o, rollback_address_o, result_o, pc_o,
	input  exec_pkg::lane_t cache_lane_o, reg_lane_o,
	input  exec_pkg::reg_index_t writeback_reg_o,
	input  logic daccess_o, rollback_o, has_writeback_o, was_access_o,
	output logic failed_o
);
	import exec_pkg::*;

	logic failed = 1'b0;
	bypass_t model_own;
	word_t model_pc;
	logic model_access;
	lane_t model_lane;
	word_t exp_op1, exp_op2, exp_alu, exp_daddress, exp_raddr, exp_result;
	lane_t exp_lane;
	logic exp_daccess, exp_rollback, jump_to_alu, taken;

	assign failed_o = failed;

	// Oldest source first, each younger match overrides it
	function automatic word_t pick_operand(input reg_index_t sel, input word_t regfile_value,
		input bypass_t own, input bypass_t mem, input bypass_t wb, input word_t pc);
		word_t v;
		v = regfile_value;
		if (wb.has_writeback && wb.writeback_reg == sel)
			v = wb.value;
		if (mem.has_writeback && mem.writeback_reg == sel)
			v = mem.value;
		if (own.has_writeback && own.writeback_reg == sel)
			v = own.value;
		if (sel == PC_REG)
			v = pc;
		return v;
	endfunction

	function automatic word_t alu_reference(input alu_op_t op, input word_t a, input word_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a + ~b + 32'd1;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SHL: return a << b[4:0];
			ALU_SHR: return a >> b[4:0];
			ALU_EQ: return (a == b) ? 32'd1 : 32'd0;
			ALU_LTU: return (a < b) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	always_comb
	begin
		exp_op1 = pick_operand(sel1_i, value1_i, model_own, mem_bypass_i, wb_bypass_i, pc_i);
		exp_op2 = ctrl_i.op2_is_imm ? immediate_i
			: pick_operand(sel2_i, value2_i, model_own, mem_bypass_i, wb_bypass_i, pc_i);
		exp_alu = alu_reference(ctrl_i.alu_op, exp_op1, exp_op2);
		exp_daddress = exp_alu & 32'hffff_ffc0;
		exp_lane = exp_alu[5:2];
		exp_daccess = ctrl_i.is_mem && !flush_i;
		exp_result = (ctrl_i.branch_kind == BR_CALL) ? pc_i : exp_alu;
		jump_to_alu = ctrl_i.has_writeback && ctrl_i.writeback_reg == PC_REG
			&& !ctrl_i.is_mem && ctrl_i.branch_kind == BR_NONE;
		case (ctrl_i.branch_kind)
			BR_ZERO: taken = exp_op1 == '0;
			BR_NZERO: taken = exp_op1 != '0;
			BR_GOTO, BR_CALL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
		exp_rollback = jump_to_alu || taken;
		// Offset is two's complement, top bit weighs minus 2^19
		if (jump_to_alu)
			exp_raddr = exp_alu;
		else if (taken)
			exp_raddr = pc_i + {12'd0, ctrl_i.branch_offset}
				- (ctrl_i.branch_offset[19] ? 32'h0010_0000 : 32'd0);
		else
			exp_raddr = '0;
	end

	// Model of the stage registers
	always_ff @(posedge clk)
	begin
		if (reset_i || flush_i)
		begin
			model_own <= '0;
			model_pc <= '0;
			model_access <= 1'b0;
			model_lane <= '0;
		end
		else
		begin
			model_own.has_writeback <= ctrl_i.has_writeback;
			model_own.writeback_reg <= ctrl_i.writeback_reg;
			model_own.value <= exp_result;
			model_pc <= pc_i;
			model_access <= exp_daccess;
			model_lane <= exp_lane;
		end
	end

	task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
		$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		failed = 1'b1;
	endtask

	task automatic report_problem(input string what);
		$display("Fail at %0t ns: %s", $time, what);
		failed = 1'b1;
	endtask

	assert property (@(posedge clk) disable iff (reset_i) daddress_o == exp_daddress)
	else report_mismatch("daddress_o", $sampled(exp_daddress), $sampled(daddress_o));
	assert property (@(posedge clk) disable iff (reset_i) cache_lane_o == exp_lane)
	else report_mismatch("cache_lane_o", word_t'($sampled(exp_lane)),
		word_t'($sampled(cache_lane_o)));
	assert property (@(posedge clk) disable iff (reset_i) daccess_o == exp_daccess)
	else report_mismatch("daccess_o", word_t'($sampled(exp_daccess)),
		word_t'($sampled(daccess_o)));
	assert property (@(posedge clk) disable iff (reset_i) rollback_o == exp_rollback)
	else report_mismatch("rollback_o", word_t'($sampled(exp_rollback)),
		word_t'($sampled(rollback_o)));
	assert property (@(posedge clk) disable iff (reset_i) rollback_address_o == exp_raddr)
	else report_mismatch("rollback_address_o", $sampled(exp_raddr),
		$sampled(rollback_address_o));
	assert property (@(posedge clk) disable iff (reset_i) result_o == model_own.value)
	else report_mismatch("result_o", $sampled(model_own.value), $sampled(result_o));
	assert property (@(posedge clk) disable iff (reset_i)
		has_writeback_o == model_own.has_writeback)
	else report_mismatch("has_writeback_o", word_t'($sampled(model_own.has_writeback)),
		word_t'($sampled(has_writeback_o)));
	assert property (@(posedge clk) disable iff (reset_i)
		writeback_reg_o == model_own.writeback_reg)
	else report_mismatch("writeback_reg_o", word_t'($sampled(model_own.writeback_reg)),
		word_t'($sampled(writeback_reg_o)));
	assert property (@(posedge clk) disable iff (reset_i) pc_o == model_pc)
	else report_mismatch("pc_o", $sampled(model_pc), $sampled(pc_o));
	assert property (@(posedge clk) disable iff (reset_i) was_access_o == model_access)
	else report_mismatch("was_access_o", word_t'($sampled(model_access)),
		word_t'($sampled(was_access_o)));
	assert property (@(posedge clk) disable iff (reset_i) reg_lane_o == model_lane)
	else report_mismatch("reg_lane_o", word_t'($sampled(model_lane)),
		word_t'($sampled(reg_lane_o)));
	assert property (@(posedge clk) disable iff (reset_i)
		flush_i |=> (!has_writeback_o && !was_access_o && result_o == '0))
	else report_problem("registered outputs were not cleared after a flush");

endmodule

// File: tb/tb_execute.sv
// Execute stage testbench
`timescale 1ns/1ns

module tb_execute;
	import exec_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 2;
	localparam int RANDOM_CYCLES = 500;
	// Reset, about 30 directed and 500 random cycles, with room to spare
	localparam int TIMEOUT_CYCLES = 1000;

	logic clk;
	logic reset_i;
	logic flush_i;
	exec_ctrl_t ctrl_i;
	word_t pc_i, immediate_i, value1_i, value2_i;
	reg_index_t sel1_i, sel2_i;
	bypass_t mem_bypass_i, wb_bypass_i;
	word_t daddress_o, rollback_address_o, result_o, pc_o;
	lane_t cache_lane_o, reg_lane_o;
	logic daccess_o, rollback_o, has_writeback_o, was_access_o;
	reg_index_t writeback_reg_o;
	logic check_failed;
	int cycle_count = 0;
	integer seed;
	word_t rnd;

	execute_stage u_dut (.*);

	exec_checker u_checker (.*, .failed_o(check_failed));

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Checks failed");
			$fatal(1, "timeout: stimulus did not finish");
		end
	end

	always @(posedge check_failed)
	begin
		$display("Checks failed");
		$fatal(1, "stopping at the first mismatch");
	end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// Bubble with no bypass sources
	task automatic clear_inputs();
		flush_i = 1'b0;
		ctrl_i = '0;
		pc_i = '0;
		immediate_i = '0;
		value1_i = '0;
		value2_i = '0;
		sel1_i = '0;
		sel2_i = '0;
		mem_bypass_i = '0;
		wb_bypass_i = '0;
	endtask

	task automatic issue_alu(input alu_op_t op, input reg_index_t src1, input word_t val1,
		input reg_index_t src2, input word_t val2, input reg_index_t dest, input logic use_imm);
		ctrl_i = '0;
		ctrl_i.alu_op = op;
		ctrl_i.op2_is_imm = use_imm;
		ctrl_i.has_writeback = 1'b1;
		ctrl_i.writeback_reg = dest;
		sel1_i = src1;
		value1_i = val1;
		sel2_i = src2;
		value2_i = val2;
		next_cycle();
	endtask

	// Link register for calls is r30
	task automatic issue_branch(input branch_kind_t kind, input reg_index_t src1,
		input word_t val1, input logic [OFFSET_WIDTH-1:0] offset, input logic link);
		ctrl_i = '0;
		ctrl_i.branch_kind = kind;
		ctrl_i.branch_offset = offset;
		ctrl_i.has_writeback = link;
		ctrl_i.writeback_reg = 5'd30;
		sel1_i = src1;
		value1_i = val1;
		next_cycle();
	endtask

	// Load into r31 must not look like a jump
	task automatic issue_mem(input word_t base, input word_t offset, input logic kill);
		ctrl_i = '0;
		ctrl_i.is_mem = 1'b1;
		ctrl_i.op2_is_imm = 1'b1;
		ctrl_i.has_writeback = 1'b1;
		ctrl_i.writeback_reg = PC_REG;
		sel1_i = 5'd3;
		value1_i = base;
		immediate_i = offset;
		flush_i = kill;
		next_cycle();
		flush_i = 1'b0;
	endtask

	task automatic run_directed();
		int i;
		pc_i = 32'h0000_1000;
		// Every code once, two of them unused
		for (i = 0; i < 11; i++)
			issue_alu(alu_op_t'(i), 5'd3, 32'hf0f0_1234 + i, 5'd4, 32'h13 * i, 5'd20, 1'b0);
		immediate_i = 32'h0000_0123;
		issue_alu(ALU_SUB, 5'd3, 32'h0000_1000, 5'd4, 32'h0, 5'd20, 1'b1);
		issue_alu(ALU_LTU, 5'd3, 32'h5, 5'd4, 32'h5, 5'd20, 1'b1);
		// Own result, then mem, then wb, then register file
		issue_alu(ALU_ADD, 5'd3, 32'd100, 5'd4, 32'd5, 5'd5, 1'b0);
		mem_bypass_i = '{1'b1, 5'd5, 32'h0000_aaaa};
		wb_bypass_i = '{1'b1, 5'd5, 32'h0000_bbbb};
		issue_alu(ALU_ADD, 5'd5, 32'd1, 5'd5, 32'd2, 5'd6, 1'b0);
		issue_alu(ALU_XOR, 5'd5, 32'd1, 5'd7, 32'd3, 5'd8, 1'b0);
		mem_bypass_i.has_writeback = 1'b0;
		issue_alu(ALU_OR, 5'd9, 32'd4, 5'd5, 32'd1, 5'd8, 1'b0);
		wb_bypass_i.has_writeback = 1'b0;
		issue_alu(ALU_ADD, 5'd5, 32'd77, 5'd9, 32'd0, 5'd8, 1'b0);
		// Jump through r31, then r31 claimed by every stage
		issue_alu(ALU_ADD, 5'd3, 32'h0000_2000, 5'd4, 32'h40, PC_REG, 1'b0);
		mem_bypass_i = '{1'b1, PC_REG, 32'h1111_1111};
		wb_bypass_i = '{1'b1, PC_REG, 32'h2222_2222};
		issue_alu(ALU_ADD, PC_REG, 32'd9, PC_REG, 32'd9, 5'd12, 1'b0);
		mem_bypass_i = '0;
		wb_bypass_i = '0;
		pc_i = 32'h0000_4000;
		issue_branch(BR_CALL, 5'd3, 32'd0, 20'h00100, 1'b1);
		// Link value returns through the own bypass, so not zero
		issue_branch(BR_ZERO, 5'd30, 32'd0, 20'h00010, 1'b0);
		issue_branch(BR_ZERO, 5'd3, 32'd0, 20'h00010, 1'b0);
		issue_branch(BR_NZERO, 5'd3, 32'd0, 20'h00010, 1'b0);
		issue_branch(BR_NZERO, 5'd3, 32'd7, 20'hffff0, 1'b0);
		issue_branch(BR_GOTO, 5'd3, 32'd0, 20'h80000, 1'b0);
		issue_mem(32'h1234_5678, 32'h0000_002c, 1'b0);
		issue_mem(32'h0000_0ffc, 32'h0000_0008, 1'b1);
		issue_mem(32'h8000_0000, 32'hffff_fff4, 1'b0);
		flush_i = 1'b1;
		issue_alu(ALU_ADD, 5'd3, 32'd1, 5'd4, 32'd1, 5'd13, 1'b0);
		flush_i = 1'b0;
		clear_inputs();
		next_cycle();
	endtask

	// Narrow register numbers so bypass hits are common, r31 now and then
	task automatic random_cycle();
		rnd = $random(seed);
		ctrl_i.alu_op = rnd[3:0];
		ctrl_i.op2_is_imm = rnd[4];
		ctrl_i.branch_kind = rnd[7:5];
		ctrl_i.is_mem = rnd[8];
		ctrl_i.has_writeback = rnd[9];
		ctrl_i.writeback_reg = {rnd[10], rnd[10], rnd[13:11]};
		sel1_i = {rnd[14], rnd[14], rnd[17:15]};
		sel2_i = {rnd[18], rnd[18], rnd[21:19]};
		mem_bypass_i.has_writeback = rnd[22];
		mem_bypass_i.writeback_reg = {2'b00, rnd[25:23]};
		wb_bypass_i.has_writeback = rnd[26];
		wb_bypass_i.writeback_reg = {2'b00, rnd[29:27]};
		flush_i = (rnd[31:30] == 2'b00) && rnd[13];
		rnd = $random(seed);
		ctrl_i.branch_offset = rnd[19:0];
		value1_i = rnd[20] ? 32'd0 : $random(seed);
		value2_i = $random(seed);
		pc_i = $random(seed);
		immediate_i = $random(seed);
		mem_bypass_i.value = $random(seed);
		wb_bypass_i.value = $random(seed);
		next_cycle();
	endtask

	initial
	begin
		seed = 93;
		clear_inputs();
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset_i = 1'b0;
		run_directed();
		repeat (RANDOM_CYCLES) random_cycle();
		clear_inputs();
		repeat (2) next_cycle();
		if (!check_failed)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "a check failed before the end of the run");
		end
	end

endmodule
